// File: common/npc_pkg.sv
package npc_pkg;

  // Data, address and instruction widths
  localparam int XLEN   = 32;
  localparam int ILEN   = 32;
  localparam int REG_AW = 5;

  typedef enum logic [2:0] {
    KIND_OP_IMM  = 3'd0,
    KIND_OP      = 3'd1,
    KIND_LUI     = 3'd2,
    KIND_JAL     = 3'd3,
    KIND_BRANCH  = 3'd4,
    KIND_EBREAK  = 3'd5,
    KIND_ILLEGAL = 3'd6
  } inst_kind_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_EQ   = 2'd1,
    BR_NE   = 2'd2,
    BR_JAL  = 2'd3
  } br_op_e;

  typedef enum logic [1:0] {
    IFU_IDLE = 2'd0,
    IFU_ADDR = 2'd1,
    IFU_DATA = 2'd2,
    IFU_HOLD = 2'd3
  } ifu_state_e;

  // Major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [ILEN-1:0] INST_EBREAK = 32'h0010_0073;

  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: exu/npc_alu.sv
`timescale 1ns/100ps

module npc_alu (
  input  npc_pkg::alu_op_e         alu_op_i,
  input  logic [npc_pkg::XLEN-1:0] a_i,
  input  logic [npc_pkg::XLEN-1:0] b_i,
  output logic [npc_pkg::XLEN-1:0] result_o
);

  logic slt;

  assign slt = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (alu_op_i)
      npc_pkg::ALU_ADD: begin
        result_o = a_i + b_i;
      end
      npc_pkg::ALU_SUB: begin
        result_o = a_i - b_i;
      end
      npc_pkg::ALU_AND: begin
        result_o = a_i & b_i;
      end
      npc_pkg::ALU_OR: begin
        result_o = a_i | b_i;
      end
      npc_pkg::ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      npc_pkg::ALU_SLT: begin
        result_o = {{(npc_pkg::XLEN-1){1'b0}}, slt};
      end
      // LUI immediate goes straight through
      npc_pkg::ALU_PASS_B: begin
        result_o = b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// File: exu/npc_branch_unit.sv
`timescale 1ns/100ps

module npc_branch_unit (
  input  npc_pkg::br_op_e          br_op_i,
  input  logic [npc_pkg::XLEN-1:0] pc_i,
  input  logic [npc_pkg::XLEN-1:0] imm_i,
  input  logic [npc_pkg::XLEN-1:0] a_i,
  input  logic [npc_pkg::XLEN-1:0] b_i,
  output logic                     taken_o,
  output logic [npc_pkg::XLEN-1:0] target_o,
  output logic [npc_pkg::XLEN-1:0] link_o
);

  logic equal;

  assign equal    = (a_i == b_i);
  assign target_o = pc_i + imm_i;

  // Also the fall-through PC
  assign link_o   = pc_i + 32'd4;

  always_comb begin
    case (br_op_i)
      npc_pkg::BR_EQ: begin
        taken_o = equal;
      end
      npc_pkg::BR_NE: begin
        taken_o = !equal;
      end
      npc_pkg::BR_JAL: begin
        taken_o = 1'b1;
      end
      default: begin
        taken_o = 1'b0;
      end
    endcase
  end

endmodule

// File: exu/npc_wbu.sv
`timescale 1ns/100ps

module npc_wbu #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       prev_valid_i,
  input  npc_pkg::inst_kind_e        kind_i,
  input  logic [npc_pkg::REG_AW-1:0] rd_i,
  input  logic                       rwen_i,
  input  logic [npc_pkg::XLEN-1:0]   alu_result_i,
  input  logic                       taken_i,
  input  logic [npc_pkg::XLEN-1:0]   target_i,
  input  logic [npc_pkg::XLEN-1:0]   link_i,
  input  logic [npc_pkg::XLEN-1:0]   pc_in_i,
  output logic                       ready_o,
  output logic [npc_pkg::XLEN-1:0]   pc_o,
  output logic                       rf_we_o,
  output logic [npc_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [npc_pkg::XLEN-1:0]   rf_wdata_o,
  output logic                       commit_valid_o,
  output logic [npc_pkg::XLEN-1:0]   commit_pc_o,
  output logic [npc_pkg::REG_AW-1:0] commit_rd_o,
  output logic                       commit_wen_o,
  output logic [npc_pkg::XLEN-1:0]   commit_wdata_o,
  output logic [npc_pkg::XLEN-1:0]   commit_next_pc_o,
  output logic                       halt_o,
  output logic                       fault_o
);

  logic                     accept, ends_run, wen;
  logic [npc_pkg::XLEN-1:0] next_pc, wdata;

  assign ready_o  = !halt_o;
  assign accept   = prev_valid_i && ready_o;
  assign ends_run = (kind_i == npc_pkg::KIND_EBREAK) || (kind_i == npc_pkg::KIND_ILLEGAL);
  assign wen      = rwen_i && !ends_run;
  assign next_pc  = taken_i ? target_i : link_i;
  assign wdata    = (kind_i == npc_pkg::KIND_JAL) ? link_i : alu_result_i;

  // Register file sees the write at the same edge as the commit
  assign rf_we_o    = accept && wen;
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o           <= RESET_PC;
      commit_valid_o <= 1'b0;
      halt_o         <= 1'b0;
      fault_o        <= 1'b0;
    end else begin
      commit_valid_o <= accept;
      if (accept) begin
        pc_o    <= next_pc;
        halt_o  <= ends_run;
        fault_o <= (kind_i == npc_pkg::KIND_ILLEGAL);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      commit_pc_o      <= pc_in_i;
      commit_rd_o      <= rd_i;
      commit_wen_o     <= wen;
      commit_wdata_o   <= wdata;
      commit_next_pc_o <= next_pc;
    end
  end

  a_no_commit_after_halt: assert property (@(posedge clk) disable iff (rst)
    halt_o |=> !commit_valid_o && halt_o);

endmodule

// File: flist.f
+incdir+testbench
common/npc_pkg.sv
verilog/npc_regfile.sv
ifu/npc_ifu.sv
idu/npc_idu.sv
exu/npc_alu.sv
exu/npc_branch_unit.sv
exu/npc_wbu.sv
verilog/npc_top.sv
testbench/tb_clock_gen.sv
testbench/tb_npc.sv

// File: idu/npc_idu.sv
`timescale 1ns/100ps

module npc_idu #(
  parameter int NR_REGS = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       prev_valid_i,
  input  logic [npc_pkg::ILEN-1:0]   inst_i,
  input  logic                       fetch_err_i,
  input  logic [npc_pkg::XLEN-1:0]   rdata1_i,
  input  logic [npc_pkg::XLEN-1:0]   rdata2_i,
  input  logic [npc_pkg::XLEN-1:0]   pc_i,
  input  logic                       next_ready_i,
  output logic                       valid_o,
  output logic                       ready_o,
  output logic [npc_pkg::REG_AW-1:0] rs1_o,
  output logic [npc_pkg::REG_AW-1:0] rs2_o,
  output npc_pkg::inst_kind_e        kind_o,
  output npc_pkg::alu_op_e           alu_op_o,
  output npc_pkg::br_op_e            br_op_o,
  output logic [npc_pkg::XLEN-1:0]   op_a_o,
  output logic [npc_pkg::XLEN-1:0]   op_b_o,
  output logic [npc_pkg::XLEN-1:0]   imm_o,
  output logic [npc_pkg::REG_AW-1:0] rd_o,
  output logic                       rwen_o,
  output logic [npc_pkg::XLEN-1:0]   pc_o
);

  logic [6:0]                 opcode, funct7;
  logic [2:0]                 funct3;
  logic [npc_pkg::REG_AW-1:0] rd;
  logic [npc_pkg::XLEN-1:0]   imm_i, imm_u, imm_j, imm_b, imm;
  logic                       use_imm, rwen, uses_rs1, uses_rs2, reg_bad, bad;
  logic                       accept, valid_q;
  npc_pkg::inst_kind_e        kind;
  npc_pkg::alu_op_e           alu_op;
  npc_pkg::br_op_e            br_op;

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];
  assign funct7 = inst_i[31:25];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    kind     = npc_pkg::KIND_ILLEGAL;
    alu_op   = npc_pkg::ALU_ADD;
    br_op    = npc_pkg::BR_NONE;
    imm      = imm_i;
    use_imm  = 1'b0;
    rwen     = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      npc_pkg::OPC_OP_IMM: begin
        kind     = npc_pkg::KIND_OP_IMM;
        use_imm  = 1'b1;
        rwen     = 1'b1;
        uses_rs1 = 1'b1;
        case (funct3)
          3'b000:  alu_op = npc_pkg::ALU_ADD;
          3'b010:  alu_op = npc_pkg::ALU_SLT;
          3'b100:  alu_op = npc_pkg::ALU_XOR;
          3'b110:  alu_op = npc_pkg::ALU_OR;
          3'b111:  alu_op = npc_pkg::ALU_AND;
          default: kind = npc_pkg::KIND_ILLEGAL;
        endcase
      end
      npc_pkg::OPC_OP: begin
        kind     = npc_pkg::KIND_OP;
        rwen     = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = npc_pkg::ALU_ADD;
          10'b0100000_000: alu_op = npc_pkg::ALU_SUB;
          10'b0000000_010: alu_op = npc_pkg::ALU_SLT;
          10'b0000000_100: alu_op = npc_pkg::ALU_XOR;
          10'b0000000_110: alu_op = npc_pkg::ALU_OR;
          10'b0000000_111: alu_op = npc_pkg::ALU_AND;
          default:         kind = npc_pkg::KIND_ILLEGAL;
        endcase
      end
      npc_pkg::OPC_LUI: begin
        kind    = npc_pkg::KIND_LUI;
        alu_op  = npc_pkg::ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        rwen    = 1'b1;
      end
      npc_pkg::OPC_JAL: begin
        kind  = npc_pkg::KIND_JAL;
        br_op = npc_pkg::BR_JAL;
        imm   = imm_j;
        rwen  = 1'b1;
      end
      npc_pkg::OPC_BRANCH: begin
        kind     = npc_pkg::KIND_BRANCH;
        imm      = imm_b;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case (funct3)
          3'b000:  br_op = npc_pkg::BR_EQ;
          3'b001:  br_op = npc_pkg::BR_NE;
          default: kind = npc_pkg::KIND_ILLEGAL;
        endcase
      end
      npc_pkg::OPC_SYSTEM: begin
        if (inst_i == npc_pkg::INST_EBREAK) begin
          kind = npc_pkg::KIND_EBREAK;
        end
      end
      default: kind = npc_pkg::KIND_ILLEGAL;
    endcase
  end

  // Only matters for the reduced register set
  assign reg_bad = (rwen && int'(rd) >= NR_REGS)
                || (uses_rs1 && int'(rs1_o) >= NR_REGS)
                || (uses_rs2 && int'(rs2_o) >= NR_REGS);
  assign bad     = fetch_err_i || reg_bad || kind == npc_pkg::KIND_ILLEGAL;

  assign ready_o = !valid_q || next_ready_i;
  assign accept  = prev_valid_i && ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (next_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      kind_o   <= bad ? npc_pkg::KIND_ILLEGAL : kind;
      alu_op_o <= alu_op;
      br_op_o  <= bad ? npc_pkg::BR_NONE : br_op;
      op_a_o   <= rdata1_i;
      op_b_o   <= use_imm ? imm : rdata2_i;
      imm_o    <= imm;
      rd_o     <= rd;
      rwen_o   <= rwen && !bad;
      pc_o     <= pc_i;
    end
  end

  assign valid_o = valid_q;

endmodule

// File: ifu/npc_ifu.sv
`timescale 1ns/100ps

module npc_ifu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [npc_pkg::XLEN-1:0] pc_i,
  input  logic                     start_i,
  input  logic                     halt_i,
  output logic [npc_pkg::XLEN-1:0] mem_araddr_o,
  output logic                     mem_arvalid_o,
  input  logic                     mem_arready_i,
  input  logic                     mem_rvalid_i,
  input  logic [npc_pkg::ILEN-1:0] mem_rdata_i,
  input  logic [1:0]               mem_rresp_i,
  output logic                     mem_rready_o,
  input  logic                     next_ready_i,
  output logic                     valid_o,
  output logic [npc_pkg::ILEN-1:0] inst_o,
  output logic                     fetch_err_o
);

  npc_pkg::ifu_state_e state_q;

  // First fetch after reset needs no commit to start it
  logic                     boot_q;
  logic [npc_pkg::XLEN-1:0] addr_q;
  logic [npc_pkg::ILEN-1:0] inst_q;
  logic                     err_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= npc_pkg::IFU_IDLE;
      boot_q  <= 1'b1;
    end else begin
      case (state_q)
        npc_pkg::IFU_IDLE: begin
          if ((start_i || boot_q) && !halt_i) begin
            state_q <= npc_pkg::IFU_ADDR;
            boot_q  <= 1'b0;
          end
        end
        npc_pkg::IFU_ADDR: begin
          if (mem_arready_i) begin
            state_q <= npc_pkg::IFU_DATA;
          end
        end
        npc_pkg::IFU_DATA: begin
          if (mem_rvalid_i) begin
            state_q <= npc_pkg::IFU_HOLD;
          end
        end
        default: begin
          if (next_ready_i) begin
            state_q <= npc_pkg::IFU_IDLE;
          end
        end
      endcase
    end
  end

  // Address follows the PC until the request goes out
  always_ff @(posedge clk) begin
    if (state_q == npc_pkg::IFU_IDLE) begin
      addr_q <= pc_i;
    end
    if (state_q == npc_pkg::IFU_DATA && mem_rvalid_i) begin
      inst_q <= mem_rdata_i;
      err_q  <= (mem_rresp_i != npc_pkg::RESP_OKAY);
    end
  end

  assign mem_araddr_o  = addr_q;
  assign mem_arvalid_o = (state_q == npc_pkg::IFU_ADDR);
  assign mem_rready_o  = (state_q == npc_pkg::IFU_DATA);
  assign valid_o       = (state_q == npc_pkg::IFU_HOLD);
  assign inst_o        = inst_q;
  assign fetch_err_o   = err_q;

  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_arvalid_o && !mem_arready_i)
      |=> (state_q == npc_pkg::IFU_ADDR) && $stable(mem_araddr_o));

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_npc -f flist.f -o sim_npc
./obj_dir/sim_npc > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
grep -q "All tests passed" sim.log
exit 0

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  initial clk_o = 1'b0;
  always #20 clk_o = ~clk_o;

  // Power-on reset, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: testbench/tb_npc_ref.svh
`ifndef TB_NPC_REF_SVH
`define TB_NPC_REF_SVH

typedef struct packed {
  logic [31:0] pc;
  logic [4:0]  rd;
  logic        wen;
  logic [31:0] wdata;
  logic [31:0] next_pc;
  logic        halt;
  logic        fault;
} commit_t;

function automatic logic [31:0] op_rr(input logic [9:0] f7f3, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
  return {f7f3[9:3], rs2, rs1, f7f3[2:0], rd, npc_pkg::OPC_OP};
endfunction

function automatic logic [31:0] op_ri(input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, npc_pkg::OPC_OP_IMM};
endfunction

function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
  return {imm, rd, npc_pkg::OPC_LUI};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, npc_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], npc_pkg::OPC_BRANCH};
endfunction

// Architectural step on ref_pc and ref_regs
function automatic commit_t ref_step(input logic [31:0] inst, input logic err);
  commit_t     c;
  logic [31:0] a, b, immi;
  logic        legal;
  a     = ref_regs[inst[19:15]];
  b     = ref_regs[inst[24:20]];
  immi  = {{20{inst[31]}}, inst[31:20]};
  legal = 1'b1;
  c     = '0;
  c.pc      = ref_pc;
  c.rd      = inst[11:7];
  c.next_pc = ref_pc + 32'd4;
  if (err) begin
    legal = 1'b0;
  end else begin
    case (inst[6:0])
      7'b0010011: begin
        c.wen = 1'b1;
        case (inst[14:12])
          3'b000:  c.wdata = a + immi;
          3'b010:  c.wdata = {31'd0, $signed(a) < $signed(immi)};
          3'b100:  c.wdata = a ^ immi;
          3'b110:  c.wdata = a | immi;
          3'b111:  c.wdata = a & immi;
          default: legal = 1'b0;
        endcase
      end
      7'b0110011: begin
        c.wen = 1'b1;
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: c.wdata = a + b;
          10'b0100000_000: c.wdata = a - b;
          10'b0000000_010: c.wdata = {31'd0, $signed(a) < $signed(b)};
          10'b0000000_100: c.wdata = a ^ b;
          10'b0000000_110: c.wdata = a | b;
          10'b0000000_111: c.wdata = a & b;
          default:         legal = 1'b0;
        endcase
      end
      7'b0110111: begin
        c.wen   = 1'b1;
        c.wdata = {inst[31:12], 12'd0};
      end
      7'b1101111: begin
        c.wen     = 1'b1;
        c.wdata   = ref_pc + 32'd4;
        c.next_pc = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'b1100011: begin
        if (inst[14:12] == 3'b000 || inst[14:12] == 3'b001) begin
          if ((a == b) == (inst[14:12] == 3'b000)) begin
            c.next_pc = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end else begin
          legal = 1'b0;
        end
      end
      default: begin
        if (inst == 32'h0010_0073) begin
          c.halt = 1'b1;
        end else begin
          legal = 1'b0;
        end
      end
    endcase
  end
  if (!legal) begin
    c.wen   = 1'b0;
    c.halt  = 1'b1;
    c.fault = 1'b1;
  end
  if (c.wen && c.rd != 5'd0) begin
    ref_regs[c.rd] = c.wdata;
  end
  ref_pc = c.next_pc;
  return c;
endfunction

`endif

// File: testbench/tb_npc.sv
`timescale 1ns/100ps

module tb_npc;

  localparam int RAND_LEN    = 40;
  localparam int TOTAL_INSTS = 2 * (RAND_LEN + 1) + 9 + 12 + 2 + 2 + 3;
  localparam int WATCHDOG_NS = (TOTAL_INSTS * 40 + 6 * 40 + 500) * 40;

  logic        clk, gen_rst, test_rst, rst;
  logic [31:0] mem_araddr, mem_rdata;
  logic        mem_arvalid, mem_arready, mem_rvalid, mem_rready;
  logic [1:0]  mem_rresp;
  logic        commit_valid, commit_wen, halt, fault;
  logic [4:0]  commit_rd;
  logic [31:0] commit_pc, commit_wdata, commit_next_pc;

  logic [31:0] mem [256];
  logic [31:0] err_addr, ref_pc, req_addr, addr_seen;
  logic [31:0] ref_regs [32];
  logic        bp_on, pending, arv_seen, rrdy_seen, ref_done, late_fetch;
  logic [95:0] cur_seq [$];
  logic [95:0] base_seq [$];
  logic [31:0] prog [$];
  logic [31:0] rnd;
  logic [3:0]  delay;
  integer      seed = 86;
  int          checks, errors;

  `include "tb_npc_ref.svh"

  assign rst = gen_rst | test_rst;

  tb_clock_gen #(.RST_CYCLES(16)) clock_gen_i (.clk_o(clk), .rst_o(gen_rst));

  npc_top npc_top_i (
    .clk(clk), .rst(rst),
    .mem_araddr_o(mem_araddr), .mem_arvalid_o(mem_arvalid), .mem_arready_i(mem_arready),
    .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata), .mem_rresp_i(mem_rresp),
    .mem_rready_o(mem_rready),
    .commit_valid_o(commit_valid), .commit_pc_o(commit_pc), .commit_rd_o(commit_rd),
    .commit_wen_o(commit_wen), .commit_wdata_o(commit_wdata),
    .commit_next_pc_o(commit_next_pc), .halt_o(halt), .fault_o(fault)
  );

  initial begin
    test_rst    = 1'b0;
    mem_arready = 1'b0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    mem_rresp   = npc_pkg::RESP_OKAY;
    bp_on       = 1'b0;
    err_addr    = 32'hffff_fffc;
  end

  // Memory model, sees last posedge handshakes from what it drove
  always @(negedge clk) begin
    if (rst) begin
      mem_arready = 1'b0;
      mem_rvalid  = 1'b0;
      pending     = 1'b0;
      arv_seen    = 1'b0;
      rrdy_seen   = 1'b0;
    end else begin
      rnd = $random(seed);
      if (mem_arready && arv_seen) begin
        check_fetch_addr(addr_seen, ref_pc);
        pending  = 1'b1;
        req_addr = addr_seen;
        delay    = bp_on ? rnd[7:4] : 4'd0;
      end
      if (mem_rvalid && rrdy_seen) begin
        mem_rvalid = 1'b0;
      end
      if (pending && !mem_rvalid) begin
        if (delay == 4'd0) begin
          mem_rvalid = 1'b1;
          mem_rdata  = mem[req_addr[9:2]];
          mem_rresp  = (req_addr == err_addr) ? 2'b10 : npc_pkg::RESP_OKAY;
          pending    = 1'b0;
        end else begin
          delay = delay - 4'd1;
        end
      end
      mem_arready = bp_on ? (rnd[1:0] == 2'b00) : 1'b1;
      arv_seen    = mem_arvalid;
      rrdy_seen   = mem_rready;
      addr_seen   = mem_araddr;
    end
  end

  task automatic check_fetch_addr(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error mem_araddr_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error commit_pc_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_write(input logic [4:0] rd, input logic wen, input logic [31:0] wdata,
                             input commit_t exp);
    checks++;
    if (wen !== exp.wen) begin
      errors++;
      $display("error commit_wen_o: got %h expected %h", wen, exp.wen);
    end else if (exp.wen && (rd !== exp.rd || wdata !== exp.wdata)) begin
      errors++;
      $display("error commit_rd_o/commit_wdata_o: got %h/%h expected %h/%h",
               rd, wdata, exp.rd, exp.wdata);
    end
  endtask

  task automatic check_next_pc(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error commit_next_pc_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_halt(input logic got_halt, input logic got_fault, input commit_t exp);
    checks++;
    if (got_halt !== exp.halt || got_fault !== exp.fault) begin
      errors++;
      $display("error halt_o/fault_o: got %h/%h expected %h/%h",
               got_halt, got_fault, exp.halt, exp.fault);
    end
  endtask

  function automatic bit same_commits();
    if (cur_seq.size() != base_seq.size()) begin
      return 1'b0;
    end
    foreach (cur_seq[i]) begin
      if (cur_seq[i] !== base_seq[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Compare process
  always @(negedge clk) begin
    commit_t exp;
    if (!rst && halt && mem_arvalid) begin
      late_fetch = 1'b1;
    end
    if (!rst && commit_valid) begin
      if (ref_done) begin
        errors++;
        $display("a commit came after the reference program had halted");
      end else begin
        exp = ref_step(mem[ref_pc[9:2]], ref_pc == err_addr);
        ref_done = exp.halt;
        check_pc(commit_pc, exp.pc);
        check_write(commit_rd, commit_wen, commit_wdata, exp);
        check_next_pc(commit_next_pc, exp.next_pc);
        check_halt(halt, fault, exp);
        cur_seq.push_back({commit_pc, commit_wdata, commit_next_pc});
      end
    end
  end

  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hbad0_0000 | (i << 2);
    end
    foreach (prog[i]) begin
      mem[i] = prog[i];
    end
  endtask

  task automatic run_program(input string name, input logic bp, input logic exp_fault);
    int start_err;
    int n;
    start_err = errors;
    load_program();
    bp_on = bp;
    ref_pc = '0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_done   = 1'b0;
    late_fetch = 1'b0;
    cur_seq.delete();
    @(negedge clk);
    test_rst = 1'b1;
    repeat (16) @(negedge clk);
    test_rst = 1'b0;
    n = 0;
    while (!halt && n < prog.size() * 40) begin
      @(negedge clk);
      n++;
    end
    repeat (10) @(negedge clk);
    if (!halt) begin
      errors++;
      $display("%s: the core did not halt in time", name);
    end else if (fault !== exp_fault) begin
      errors++;
      $display("%s: fault_o was %b when %b was expected", name, fault, exp_fault);
    end
    if (!ref_done) begin
      errors++;
      $display("%s: the core stopped before the reference program ended", name);
    end
    if (late_fetch) begin
      errors++;
      $display("%s: a fetch was issued after halt", name);
    end
    $display("%s: %s", name, (errors == start_err) ? "pass" : "FAIL");
  endtask

  task automatic build_random();
    logic [2:0] f3s [5];
    logic [9:0] rrs [6];
    logic [31:0] r;
    f3s = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    rrs = '{10'h000, 10'h100, 10'h002, 10'h004, 10'h006, 10'h007};
    prog.delete();
    for (int i = 0; i < RAND_LEN; i++) begin
      r = $random(seed);
      if (r[0] || i < 6) begin
        prog.push_back(op_ri(f3s[int'(r[3:1]) % 5], r[8:4], r[13:9], r[25:14]));
      end else begin
        prog.push_back(op_rr(rrs[int'(r[3:1]) % 6], r[8:4], r[13:9], r[18:14]));
      end
    end
    prog.push_back(npc_pkg::INST_EBREAK);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within the expected time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    checks = 0;
    errors = 0;
    @(negedge gen_rst);

    seed = 86;
    build_random();
    run_program("test 1 random alu", 1'b0, 1'b0);
    base_seq = cur_seq;

    prog = '{op_ri(3'b000, 5'd0, 5'd0, 12'd5), op_ri(3'b000, 5'd1, 5'd0, 12'd0),
             lui_word(5'd0, 20'habcde), lui_word(5'd2, 20'h12345),
             op_ri(3'b000, 5'd2, 5'd2, 12'h678), op_rr(10'h000, 5'd3, 5'd0, 5'd2),
             op_rr(10'h006, 5'd0, 5'd2, 5'd2), op_rr(10'h000, 5'd4, 5'd0, 5'd0),
             npc_pkg::INST_EBREAK};
    run_program("test 2 x0 and lui", 1'b0, 1'b0);

    prog = '{op_ri(3'b000, 5'd1, 5'd0, 12'd5), op_ri(3'b000, 5'd2, 5'd0, 12'd5),
             branch_word(3'b000, 5'd1, 5'd2, 13'd8), op_ri(3'b000, 5'd3, 5'd0, 12'd1),
             branch_word(3'b001, 5'd1, 5'd2, 13'd8), op_ri(3'b000, 5'd4, 5'd0, 12'd7),
             jal_word(5'd5, 21'd8), op_ri(3'b000, 5'd6, 5'd0, 12'd1),
             branch_word(3'b001, 5'd1, 5'd4, 13'd8), op_ri(3'b000, 5'd7, 5'd0, 12'd9),
             branch_word(3'b000, 5'd1, 5'd4, 13'd8), npc_pkg::INST_EBREAK};
    run_program("test 3 control flow", 1'b0, 1'b0);

    seed = 86;
    build_random();
    run_program("test 4 back-pressure", 1'b1, 1'b0);
    if (!same_commits()) begin
      errors++;
      $display("test 4: the commit sequence differs from the run without back-pressure");
    end

    prog = '{op_ri(3'b000, 5'd1, 5'd0, 12'd1), npc_pkg::INST_EBREAK};
    run_program("test 5 ebreak", 1'b0, 1'b0);

    prog = '{op_ri(3'b000, 5'd1, 5'd0, 12'd1), 32'hffff_ffff};
    run_program("test 6a illegal", 1'b0, 1'b1);
    prog = '{op_ri(3'b000, 5'd1, 5'd0, 12'd1), op_ri(3'b000, 5'd2, 5'd0, 12'd2),
             op_ri(3'b000, 5'd3, 5'd0, 12'd3)};
    err_addr = 32'd8;
    run_program("test 6b bus error", 1'b0, 1'b1);
    err_addr = 32'hffff_fffc;

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/npc_regfile.sv
`timescale 1ns/100ps

module npc_regfile #(
  parameter int NR_REGS = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       we_i,
  input  logic [npc_pkg::REG_AW-1:0] waddr_i,
  input  logic [npc_pkg::XLEN-1:0]   wdata_i,
  input  logic [npc_pkg::REG_AW-1:0] raddr1_i,
  input  logic [npc_pkg::REG_AW-1:0] raddr2_i,
  output logic [npc_pkg::XLEN-1:0]   rdata1_o,
  output logic [npc_pkg::XLEN-1:0]   rdata2_o
);

  localparam int IW = $clog2(NR_REGS);

  logic [npc_pkg::XLEN-1:0] regs_q [NR_REGS];

  // x0 is cleared on reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0 && int'(waddr_i) < NR_REGS) begin
      regs_q[waddr_i[IW-1:0]] <= wdata_i;
    end
  end

  assign rdata1_o = (int'(raddr1_i) < NR_REGS) ? regs_q[raddr1_i[IW-1:0]] : '0;
  assign rdata2_o = (int'(raddr2_i) < NR_REGS) ? regs_q[raddr2_i[IW-1:0]] : '0;

endmodule

// File: verilog/npc_top.sv
`timescale 1ns/100ps

module npc_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000,
  parameter int          NR_REGS  = 32
) (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] mem_araddr_o,
  output logic        mem_arvalid_o,
  input  logic        mem_arready_i,
  input  logic        mem_rvalid_i,
  input  logic [31:0] mem_rdata_i,
  input  logic [1:0]  mem_rresp_i,
  output logic        mem_rready_o,
  output logic        commit_valid_o,
  output logic [31:0] commit_pc_o,
  output logic [4:0]  commit_rd_o,
  output logic        commit_wen_o,
  output logic [31:0] commit_wdata_o,
  output logic [31:0] commit_next_pc_o,
  output logic        halt_o,
  output logic        fault_o
);

  logic [31:0] pc;
  logic [31:0] inst;
  logic        ifu_valid, fetch_err;
  logic        idu_valid, idu_ready, wbu_ready;
  logic [4:0]  rs1, rs2, rd;
  logic        rwen;
  logic [31:0] rdata1, rdata2;
  logic [31:0] op_a, op_b, imm, idu_pc;
  logic [31:0] alu_result, br_target, br_link;
  logic        br_taken;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;

  npc_pkg::inst_kind_e kind;
  npc_pkg::alu_op_e    alu_op;
  npc_pkg::br_op_e     br_op;

  npc_ifu ifu_i (
    .clk(clk), .rst(rst),
    .pc_i(pc), .start_i(commit_valid_o), .halt_i(halt_o),
    .mem_araddr_o(mem_araddr_o), .mem_arvalid_o(mem_arvalid_o),
    .mem_arready_i(mem_arready_i),
    .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
    .mem_rresp_i(mem_rresp_i), .mem_rready_o(mem_rready_o),
    .next_ready_i(idu_ready),
    .valid_o(ifu_valid), .inst_o(inst), .fetch_err_o(fetch_err)
  );

  npc_idu #(.NR_REGS(NR_REGS)) idu_i (
    .clk(clk), .rst(rst),
    .prev_valid_i(ifu_valid), .inst_i(inst), .fetch_err_i(fetch_err),
    .rdata1_i(rdata1), .rdata2_i(rdata2), .pc_i(pc),
    .next_ready_i(wbu_ready),
    .valid_o(idu_valid), .ready_o(idu_ready),
    .rs1_o(rs1), .rs2_o(rs2),
    .kind_o(kind), .alu_op_o(alu_op), .br_op_o(br_op),
    .op_a_o(op_a), .op_b_o(op_b), .imm_o(imm),
    .rd_o(rd), .rwen_o(rwen), .pc_o(idu_pc)
  );

  npc_regfile #(.NR_REGS(NR_REGS)) regfile_i (
    .clk(clk), .rst(rst),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .raddr1_i(rs1), .raddr2_i(rs2),
    .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  npc_alu alu_i (
    .alu_op_i(alu_op), .a_i(op_a), .b_i(op_b), .result_o(alu_result)
  );

  npc_branch_unit branch_i (
    .br_op_i(br_op), .pc_i(idu_pc), .imm_i(imm), .a_i(op_a), .b_i(op_b),
    .taken_o(br_taken), .target_o(br_target), .link_o(br_link)
  );

  npc_wbu #(.RESET_PC(RESET_PC)) wbu_i (
    .clk(clk), .rst(rst),
    .prev_valid_i(idu_valid), .kind_i(kind), .rd_i(rd), .rwen_i(rwen),
    .alu_result_i(alu_result),
    .taken_i(br_taken), .target_i(br_target), .link_i(br_link),
    .pc_in_i(idu_pc),
    .ready_o(wbu_ready), .pc_o(pc),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
    .commit_rd_o(commit_rd_o), .commit_wen_o(commit_wen_o),
    .commit_wdata_o(commit_wdata_o), .commit_next_pc_o(commit_next_pc_o),
    .halt_o(halt_o), .fault_o(fault_o)
  );

endmodule
